// ==== aznable_pkg.sv ====
package aznable_pkg;

	// bus and memory widths
	localparam int DATA_W = 8;
	localparam int ADDR_W = 16;
	localparam int DN_ADDR_W = 17;
	localparam int PGROM_AW = 15;
	localparam int WKRAM_AW = 14;

	// memory ranges on the raw address
	localparam logic [ADDR_W-1:0] PGROM_TOP = 16'h8000;
	localparam logic [ADDR_W-1:0] WKRAM_BASE = 16'hc000;

	// input pages, upper address byte
	localparam logic [7:0] PAGE_IN0 = 8'h80;
	localparam logic [7:0] PAGE_JOYSTICK = 8'h81;
	localparam logic [7:0] PAGE_PADDLE = 8'h84;
	localparam logic [7:0] PAGE_PS2_KEY = 8'h86;
	localparam logic [7:0] PAGE_TIMESTAMP = 8'h88;
	localparam logic [7:0] PAGE_TIMER = 8'h89;

	// low nibble of the in0 status byte
	localparam logic [3:0] IN0_FIXED = 4'b1000;

	// widths of the input source words
	localparam int JOYSTICK_W = 192;
	localparam int PADDLE_W = 48;
	localparam int PS2_KEY_W = 11;
	localparam int TIMESTAMP_W = 33;

	localparam logic [7:0] DN_INDEX_PGROM = 8'd0;

	// video timing, pixels and lines
	localparam int CNT_W = 9;
	localparam logic [CNT_W-1:0] H_ACTIVE = 9'd320;
	localparam logic [CNT_W-1:0] H_TOTAL = 9'd396;
	localparam logic [CNT_W-1:0] HS_START = 9'd330;
	localparam logic [CNT_W-1:0] HS_END = 9'd362;
	localparam logic [CNT_W-1:0] V_ACTIVE = 9'd240;
	localparam logic [CNT_W-1:0] V_TOTAL = 9'd256;
	localparam logic [CNT_W-1:0] VS_START = 9'd244;
	localparam logic [CNT_W-1:0] VS_END = 9'd247;

	// millisecond timer
	localparam int MS_TICKS = 24000;
	localparam int TIMER_W = 16;
	localparam int MS_PRESCALE_W = $clog2(MS_TICKS);
	localparam logic [MS_PRESCALE_W-1:0] MS_LAST = MS_PRESCALE_W'(MS_TICKS - 1);

	// cpu address, page/offset view of the same word
	typedef struct packed {
		logic [7:0] page;
		logic [7:0] offset;
	} cpu_addr_paged_t;

	typedef union packed {
		logic [ADDR_W-1:0] raw;
		cpu_addr_paged_t paged;
	} cpu_addr_t;

endpackage

// ==== video_timer.sv ====
`timescale 1ns/1ns

module video_timer (
	input logic clk_24,
	input logic reset,
	input logic ce_6,
	output logic [aznable_pkg::CNT_W-1:0] hcnt,
	output logic [aznable_pkg::CNT_W-1:0] vcnt,
	output logic hblank,
	output logic vblank,
	output logic hsync,
	output logic vsync
);

	logic [aznable_pkg::CNT_W-1:0] hcnt_next;
	logic [aznable_pkg::CNT_W-1:0] vcnt_next;
	logic h_wrap;

	// last pixel of the line
	assign h_wrap = (hcnt == aznable_pkg::H_TOTAL - 1'b1);

	always_comb
	begin
		hcnt_next = h_wrap ? '0 : hcnt + 1'b1;
		vcnt_next = vcnt;
		// line counter only moves on the horizontal wrap
		if (h_wrap)
		begin
			if (vcnt == aznable_pkg::V_TOTAL - 1'b1)
				vcnt_next = '0;
			else
				vcnt_next = vcnt + 1'b1;
		end
	end

	// blank and sync decoded from the next counts
	// so they line up with the counters
	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			hcnt <= '0;
			vcnt <= '0;
			hblank <= 1'b0;
			vblank <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end
		else if (ce_6)
		begin
			hcnt <= hcnt_next;
			vcnt <= vcnt_next;
			hblank <= (hcnt_next >= aznable_pkg::H_ACTIVE);
			vblank <= (vcnt_next >= aznable_pkg::V_ACTIVE);
			// sync windows, end exclusive
			hsync <= (hcnt_next >= aznable_pkg::HS_START) && (hcnt_next < aznable_pkg::HS_END);
			vsync <= (vcnt_next >= aznable_pkg::VS_START) && (vcnt_next < aznable_pkg::VS_END);
		end
	end

endmodule

// ==== ms_timer.sv ====
`timescale 1ns/1ns

module ms_timer (
	input logic clk_24,
	input logic reset,
	input logic timer_clear,
	output logic [aznable_pkg::TIMER_W-1:0] count
);

	// clk_24 cycles within the current millisecond
	logic [aznable_pkg::MS_PRESCALE_W-1:0] prescale;

	always_ff @(posedge clk_24)
	begin
		if (reset || timer_clear)
		begin
			// restart a full millisecond from here
			prescale <= '0;
			count <= '0;
		end
		else if (prescale == aznable_pkg::MS_LAST)
		begin
			prescale <= '0;
			// free running, wraps at 16 bits
			count <= count + 1'b1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

// ==== bus_decoder.sv ====
`timescale 1ns/1ns

module bus_decoder (
	input logic clk_24,
	input logic reset,
	input aznable_pkg::cpu_addr_t cpu_addr,
	input logic cpu_rd,
	input logic cpu_wr,
	input logic [aznable_pkg::JOYSTICK_W-1:0] joystick,
	input logic [aznable_pkg::PADDLE_W-1:0] paddle,
	input logic [aznable_pkg::PS2_KEY_W-1:0] ps2_key,
	input logic [aznable_pkg::TIMESTAMP_W-1:0] timestamp,
	input logic [aznable_pkg::TIMER_W-1:0] timer_count,
	input logic hsync,
	input logic vsync,
	input logic hblank,
	input logic vblank,
	input logic [aznable_pkg::DATA_W-1:0] pgrom_q,
	input logic [aznable_pkg::DATA_W-1:0] wkram_q,
	output logic [aznable_pkg::DATA_W-1:0] cpu_din,
	output logic cpu_rdata_valid,
	output logic wkram_wr,
	output logic timer_clear
);

	logic pgrom_cs;
	logic wkram_cs;
	logic timer_cs;

	// sources zero padded to the reach of their offset bits
	// joystick 5 bits, 32 bytes
	logic [255:0] joystick_ext;
	// paddle and timestamp 3 bits, 8 bytes
	logic [63:0] paddle_ext;
	logic [63:0] timestamp_ext;
	// ps2 key 1 bit, 2 bytes
	logic [15:0] ps2_key_ext;

	logic [aznable_pkg::DATA_W-1:0] in_sel;

	// state of the read in flight
	logic rd_pgrom;
	logic rd_wkram;
	logic [aznable_pkg::DATA_W-1:0] in_byte;

	// memory ranges from the flat address
	assign pgrom_cs = (cpu_addr.raw < aznable_pkg::PGROM_TOP);
	assign wkram_cs = (cpu_addr.raw >= aznable_pkg::WKRAM_BASE);
	assign timer_cs = (cpu_addr.paged.page == aznable_pkg::PAGE_TIMER);

	assign joystick_ext = {{(256 - aznable_pkg::JOYSTICK_W){1'b0}}, joystick};
	assign paddle_ext = {{(64 - aznable_pkg::PADDLE_W){1'b0}}, paddle};
	// byte 4 carries the toggle bit 32
	assign timestamp_ext = {{(64 - aznable_pkg::TIMESTAMP_W){1'b0}}, timestamp};
	assign ps2_key_ext = {{(16 - aznable_pkg::PS2_KEY_W){1'b0}}, ps2_key};

	// input byte from the page view
	always_comb
	begin
		case (cpu_addr.paged.page)
			aznable_pkg::PAGE_IN0:
				in_sel = {hsync, vsync, hblank, vblank, aznable_pkg::IN0_FIXED};
			aznable_pkg::PAGE_JOYSTICK:
				in_sel = joystick_ext[{cpu_addr.paged.offset[4:0], 3'd0} +: 8];
			aznable_pkg::PAGE_PADDLE:
				in_sel = paddle_ext[{cpu_addr.paged.offset[2:0], 3'd0} +: 8];
			aznable_pkg::PAGE_PS2_KEY:
				in_sel = ps2_key_ext[{cpu_addr.paged.offset[0], 3'd0} +: 8];
			aznable_pkg::PAGE_TIMESTAMP:
				in_sel = timestamp_ext[{cpu_addr.paged.offset[2:0], 3'd0} +: 8];
			aznable_pkg::PAGE_TIMER:
				in_sel = timer_count[{cpu_addr.paged.offset[0], 3'd0} +: 8];
			// memory and unmapped pages
			default:
				in_sel = '0;
		endcase
	end

	// write strobes go out in the cycle of cpu_wr
	assign wkram_wr = cpu_wr && wkram_cs;
	assign timer_clear = cpu_wr && timer_cs;

	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			cpu_rdata_valid <= 1'b0;
			rd_pgrom <= 1'b0;
			rd_wkram <= 1'b0;
		end
		else
		begin
			cpu_rdata_valid <= cpu_rd;
			rd_pgrom <= cpu_rd && pgrom_cs;
			rd_wkram <= cpu_rd && wkram_cs;
		end
	end

	// input byte sampled with the strobe, same cycle the rams latch
	always_ff @(posedge clk_24)
	begin
		if (cpu_rd)
			in_byte <= in_sel;
	end

	// memory q is already one cycle late, matches the select
	assign cpu_din = rd_pgrom ? pgrom_q :
		rd_wkram ? wkram_q :
		in_byte;

endmodule

// ==== system_memory.sv ====
`timescale 1ns/1ns

module system_memory (
	input logic clk_24,
	input aznable_pkg::cpu_addr_t cpu_addr,
	input logic [aznable_pkg::DATA_W-1:0] cpu_dout,
	input logic wkram_wr,
	input logic [aznable_pkg::DN_ADDR_W-1:0] dn_addr,
	input logic [aznable_pkg::DATA_W-1:0] dn_data,
	input logic [7:0] dn_index,
	input logic dn_wr,
	output logic [aznable_pkg::DATA_W-1:0] pgrom_q,
	output logic [aznable_pkg::DATA_W-1:0] wkram_q
);

	// program rom, 0x0000 - 0x7fff
	logic [aznable_pkg::DATA_W-1:0] pgrom [0:(2**aznable_pkg::PGROM_AW)-1];
	// work ram, 0xc000 - 0xffff
	logic [aznable_pkg::DATA_W-1:0] wkram [0:(2**aznable_pkg::WKRAM_AW)-1];

	logic pgrom_wr;
	logic [aznable_pkg::PGROM_AW-1:0] pgrom_rd_addr;
	logic [aznable_pkg::PGROM_AW-1:0] pgrom_wr_addr;
	logic [aznable_pkg::WKRAM_AW-1:0] wkram_addr;

	// loader only reaches the rom on its own index
	assign pgrom_wr = dn_wr && (dn_index == aznable_pkg::DN_INDEX_PGROM);
	assign pgrom_wr_addr = dn_addr[aznable_pkg::PGROM_AW-1:0];
	assign pgrom_rd_addr = cpu_addr.raw[aznable_pkg::PGROM_AW-1:0];
	assign wkram_addr = cpu_addr.raw[aznable_pkg::WKRAM_AW-1:0];

	// cpu side is read only, download side write only
	always_ff @(posedge clk_24)
	begin
		if (pgrom_wr)
			pgrom[pgrom_wr_addr] <= dn_data;
		pgrom_q <= pgrom[pgrom_rd_addr];
	end

	// single port, read before write
	always_ff @(posedge clk_24)
	begin
		if (wkram_wr)
			wkram[wkram_addr] <= cpu_dout;
		wkram_q <= wkram[wkram_addr];
	end

endmodule

// ==== system_top.sv ====
`timescale 1ns/1ns

module system_top (
	input logic clk_24,
	input logic reset,
	input logic ce_6,
	input logic [aznable_pkg::DN_ADDR_W-1:0] dn_addr,
	input logic [aznable_pkg::DATA_W-1:0] dn_data,
	input logic [7:0] dn_index,
	input logic dn_wr,
	input aznable_pkg::cpu_addr_t cpu_addr,
	input logic [aznable_pkg::DATA_W-1:0] cpu_dout,
	input logic cpu_rd,
	input logic cpu_wr,
	input logic [aznable_pkg::JOYSTICK_W-1:0] joystick,
	input logic [aznable_pkg::PADDLE_W-1:0] paddle,
	input logic [aznable_pkg::PS2_KEY_W-1:0] ps2_key,
	input logic [aznable_pkg::TIMESTAMP_W-1:0] timestamp,
	output logic [aznable_pkg::DATA_W-1:0] cpu_din,
	output logic cpu_rdata_valid,
	output logic hsync,
	output logic vsync,
	output logic hblank,
	output logic vblank
);

	logic [aznable_pkg::TIMER_W-1:0] timer_count;
	logic timer_clear;
	logic wkram_wr;
	logic [aznable_pkg::DATA_W-1:0] pgrom_q;
	logic [aznable_pkg::DATA_W-1:0] wkram_q;

	// pixel counters stay internal, only sync and blank leave
	video_timer video_timer_inst (
		.clk_24(clk_24),
		.reset(reset),
		.ce_6(ce_6),
		.hcnt(),
		.vcnt(),
		.hblank(hblank),
		.vblank(vblank),
		.hsync(hsync),
		.vsync(vsync)
	);

	ms_timer ms_timer_inst (
		.clk_24(clk_24),
		.reset(reset),
		.timer_clear(timer_clear),
		.count(timer_count)
	);

	bus_decoder bus_decoder_inst (
		.clk_24(clk_24),
		.reset(reset),
		.cpu_addr(cpu_addr),
		.cpu_rd(cpu_rd),
		.cpu_wr(cpu_wr),
		.joystick(joystick),
		.paddle(paddle),
		.ps2_key(ps2_key),
		.timestamp(timestamp),
		.timer_count(timer_count),
		.hsync(hsync),
		.vsync(vsync),
		.hblank(hblank),
		.vblank(vblank),
		.pgrom_q(pgrom_q),
		.wkram_q(wkram_q),
		.cpu_din(cpu_din),
		.cpu_rdata_valid(cpu_rdata_valid),
		.wkram_wr(wkram_wr),
		.timer_clear(timer_clear)
	);

	// rom and ram both addressed straight from the bus
	system_memory system_memory_inst (
		.clk_24(clk_24),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.wkram_wr(wkram_wr),
		.dn_addr(dn_addr),
		.dn_data(dn_data),
		.dn_index(dn_index),
		.dn_wr(dn_wr),
		.pgrom_q(pgrom_q),
		.wkram_q(wkram_q)
	);

endmodule

// ==== tb_system.sv ====
`timescale 1ns/1ns

module tb_system;

	logic clk_24 = 1'b0;
	logic reset;
	// pixel enable one clock in four
	logic ce_6 = 1'b0;
	logic [1:0] ce_div = 2'd0;
	logic [aznable_pkg::DN_ADDR_W-1:0] dn_addr;
	logic [aznable_pkg::DATA_W-1:0] dn_data;
	logic [7:0] dn_index;
	logic dn_wr;
	aznable_pkg::cpu_addr_t cpu_addr;
	logic [aznable_pkg::DATA_W-1:0] cpu_dout;
	logic cpu_rd;
	logic cpu_wr;
	logic [aznable_pkg::JOYSTICK_W-1:0] joystick;
	logic [aznable_pkg::PADDLE_W-1:0] paddle;
	logic [aznable_pkg::PS2_KEY_W-1:0] ps2_key;
	logic [aznable_pkg::TIMESTAMP_W-1:0] timestamp;
	logic [aznable_pkg::DATA_W-1:0] cpu_din;
	logic cpu_rdata_valid;
	logic hsync;
	logic vsync;
	logic hblank;
	logic vblank;

	int errors = 0;
	int checks = 0;
	logic [31:0] lfsr_state;
	// rom image kept for the write protect check
	logic [15:0] rom_addr [8];
	logic [7:0] rom_data [8];

	system_top system_top_inst (.*);

	always #2 clk_24 = ~clk_24;

	always @(posedge clk_24)
	begin
		ce_div <= ce_div + 2'd1;
		ce_6 <= (ce_div == 2'd3);
	end

	// galois lfsr stepped once per bit
	function automatic logic lfsr_bit();
		logic out_bit;
		out_bit = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out_bit)
			lfsr_state = lfsr_state ^ 32'hb4bcd35c;
		return out_bit;
	endfunction

	function automatic logic [31:0] rand_small(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic logic [255:0] rand_wide(input int n);
		logic [255:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[254:0], lfsr_bit()};
		return v;
	endfunction

	// byte n of a source word
	// bits past its width read as zero
	function automatic logic [7:0] expected_in_byte(input logic [255:0] src, input int width,
		input int offset);
		logic [7:0] b;
		int pos;
		for (int k = 0; k < 8; k++)
		begin
			pos = offset * 8 + k;
			b[k] = (pos < width) ? src[pos] : 1'b0;
		end
		return b;
	endfunction

	task automatic check_byte(input string what, input logic [aznable_pkg::DATA_W-1:0] got,
		input logic [aznable_pkg::DATA_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: %s got %02h expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr_name(input aznable_pkg::cpu_addr_t addr,
		input logic [aznable_pkg::DATA_W-1:0] got, input logic [aznable_pkg::DATA_W-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0t: read of page %02h offset %02h got %02h expected %02h",
				$time, addr.paged.page, addr.paged.offset, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic start_read(input aznable_pkg::cpu_addr_t addr);
		@(posedge clk_24);
		cpu_addr <= addr;
		cpu_rd <= 1'b1;
	endtask

	// drop whichever strobe is up
	task automatic end_strobe();
		@(posedge clk_24);
		cpu_rd <= 1'b0;
		cpu_wr <= 1'b0;
	endtask

	// sampled on the falling edge away from the DUT updates
	task automatic wait_valid(output logic [aznable_pkg::DATA_W-1:0] data);
		data = '0;
		for (int guard = 0; guard < 16; guard++)
		begin
			@(negedge clk_24);
			if (cpu_rdata_valid)
			begin
				// valid due in the cycle right after the strobe
				check_count("clocks late for read data valid", guard, 0);
				data = cpu_din;
				return;
			end
		end
		errors++;
		$display("Timeout: read data valid never came within 16 clocks at %0t", $time);
	endtask

	task automatic bus_read(input aznable_pkg::cpu_addr_t addr,
		output logic [aznable_pkg::DATA_W-1:0] data);
		start_read(addr);
		end_strobe();
		wait_valid(data);
	endtask

	task automatic bus_write(input aznable_pkg::cpu_addr_t addr,
		input logic [aznable_pkg::DATA_W-1:0] data);
		@(posedge clk_24);
		cpu_addr <= addr;
		cpu_dout <= data;
		cpu_wr <= 1'b1;
		end_strobe();
	endtask

	task automatic download(input logic [15:0] addr, input logic [7:0] data,
		input logic [7:0] index);
		@(posedge clk_24);
		dn_addr <= {1'b0, addr};
		dn_data <= data;
		dn_index <= index;
		dn_wr <= 1'b1;
		@(posedge clk_24);
		dn_wr <= 1'b0;
	endtask

	task automatic test_pgrom_download();
		logic [31:0] rnd;
		aznable_pkg::cpu_addr_t addr;
		logic [7:0] got;
		// low bits from the index keep the addresses distinct
		for (int i = 0; i < 8; i++)
		begin
			rnd = rand_small(12);
			rom_addr[i] = {1'b0, rnd[11:0], 3'(i)};
			rnd = rand_small(8);
			rom_data[i] = rnd[7:0];
			download(rom_addr[i], rom_data[i], aznable_pkg::DN_INDEX_PGROM);
		end
		// other index must not land in rom
		for (int i = 0; i < 8; i++)
			download(rom_addr[i], ~rom_data[i], 8'd1);
		for (int i = 0; i < 8; i++)
		begin
			addr.raw = rom_addr[i];
			bus_read(addr, got);
			check_addr_name(addr, got, rom_data[i]);
		end
	endtask

	task automatic test_work_ram();
		logic [15:0] ram_addr [8];
		logic [7:0] ram_data [8];
		logic [31:0] rnd;
		aznable_pkg::cpu_addr_t addr;
		aznable_pkg::cpu_addr_t addr_b;
		logic [7:0] got;
		logic [7:0] got_b;
		for (int i = 0; i < 8; i++)
		begin
			rnd = rand_small(11);
			ram_addr[i] = {2'b11, rnd[10:0], 3'(i)};
			rnd = rand_small(8);
			ram_data[i] = rnd[7:0];
			addr.raw = ram_addr[i];
			bus_write(addr, ram_data[i]);
		end
		for (int i = 0; i < 8; i++)
		begin
			addr.raw = ram_addr[i];
			bus_read(addr, got);
			check_addr_name(addr, got, ram_data[i]);
		end
		// two reads in consecutive cycles answered in order
		addr.raw = ram_addr[2];
		addr_b.raw = ram_addr[5];
		start_read(addr);
		start_read(addr_b);
		wait_valid(got);
		end_strobe();
		wait_valid(got_b);
		check_addr_name(addr, got, ram_data[2]);
		check_addr_name(addr_b, got_b, ram_data[5]);
		// bus write into rom space is dropped
		addr.raw = rom_addr[0];
		bus_write(addr, ~rom_data[0]);
		bus_read(addr, got);
		check_addr_name(addr, got, rom_data[0]);
	endtask

	task automatic read_page(input logic [7:0] page, input logic [255:0] src, input int width,
		input int bits);
		aznable_pkg::cpu_addr_t addr;
		logic [7:0] got;
		for (int off = 0; off < (1 << bits); off++)
		begin
			addr.paged.page = page;
			addr.paged.offset = 8'(off);
			bus_read(addr, got);
			check_addr_name(addr, got, expected_in_byte(src, width, off));
		end
	endtask

	task automatic test_input_pages();
		logic [255:0] rnd;
		aznable_pkg::cpu_addr_t addr;
		logic [7:0] got;
		@(posedge clk_24);
		rnd = rand_wide(aznable_pkg::JOYSTICK_W);
		joystick <= rnd[aznable_pkg::JOYSTICK_W-1:0];
		rnd = rand_wide(aznable_pkg::PADDLE_W);
		paddle <= rnd[aznable_pkg::PADDLE_W-1:0];
		rnd = rand_wide(aznable_pkg::PS2_KEY_W);
		ps2_key <= rnd[aznable_pkg::PS2_KEY_W-1:0];
		rnd = rand_wide(aznable_pkg::TIMESTAMP_W);
		timestamp <= rnd[aznable_pkg::TIMESTAMP_W-1:0];
		// let the new words settle before taking copies
		@(posedge clk_24);
		read_page(aznable_pkg::PAGE_JOYSTICK, 256'(joystick), aznable_pkg::JOYSTICK_W, 5);
		read_page(aznable_pkg::PAGE_PADDLE, 256'(paddle), aznable_pkg::PADDLE_W, 3);
		read_page(aznable_pkg::PAGE_PS2_KEY, 256'(ps2_key), aznable_pkg::PS2_KEY_W, 1);
		read_page(aznable_pkg::PAGE_TIMESTAMP, 256'(timestamp), aznable_pkg::TIMESTAMP_W, 3);
		// timestamp byte 4 holds the lone top bit
		addr.raw = {aznable_pkg::PAGE_TIMESTAMP, 8'h04};
		bus_read(addr, got);
		check_byte("timestamp bit 32", got, {7'd0, timestamp[32]});
		// unmapped page
		rnd = rand_wide(8);
		addr.raw = {8'h82, rnd[7:0]};
		bus_read(addr, got);
		check_addr_name(addr, got, 8'h00);
	endtask

	function automatic logic video_bit(input int sel);
		case (sel)
			0: return hblank;
			1: return hsync;
			2: return vsync;
			default: return vblank;
		endcase
	endfunction

	// ce_6 pulses from one rise to the next and those spent high
	task automatic measure_video(input int sel, input int limit, output int period,
		output int high);
		logic prev;
		logic now;
		int rises;
		int guard;
		period = 0;
		high = 0;
		rises = 0;
		guard = 0;
		prev = video_bit(sel);
		while (rises < 2 && guard < limit)
		begin
			@(negedge clk_24);
			guard++;
			now = video_bit(sel);
			if (now && !prev)
				rises++;
			if (rises == 1 && ce_6)
			begin
				period++;
				if (now)
					high++;
			end
			prev = now;
		end
		if (rises < 2)
		begin
			errors++;
			$display("Timeout: video signal %0d did not rise twice within %0d clocks",
				sel, limit);
		end
	endtask

	task automatic test_video_timing();
		int period;
		int high;
		aznable_pkg::cpu_addr_t addr;
		logic [7:0] got;
		measure_video(0, 4000, period, high);
		check_count("hblank period", period, int'(aznable_pkg::H_TOTAL));
		check_count("hblank width", high, int'(aznable_pkg::H_TOTAL - aznable_pkg::H_ACTIVE));
		measure_video(1, 4000, period, high);
		check_count("hsync width", high, int'(aznable_pkg::HS_END - aznable_pkg::HS_START));
		// two rises of vsync take up to two frames
		measure_video(2, 1000000, period, high);
		check_count("vsync period", period,
			int'(aznable_pkg::H_TOTAL) * int'(aznable_pkg::V_TOTAL));
		// vblank spans the lines past the active area
		measure_video(3, 1000000, period, high);
		check_count("vblank width", high,
			int'(aznable_pkg::V_TOTAL - aznable_pkg::V_ACTIVE) * int'(aznable_pkg::H_TOTAL));
		addr.raw = {aznable_pkg::PAGE_IN0, 8'h00};
		for (int i = 0; i < 4; i++)
		begin
			repeat (rand_small(6)) @(posedge clk_24);
			bus_read(addr, got);
			check_byte("in0 low nibble", got & 8'h0f, 8'h08);
		end
	endtask

	task automatic test_ms_timer();
		aznable_pkg::cpu_addr_t addr;
		logic [7:0] lo;
		logic [7:0] hi;
		addr.raw = {aznable_pkg::PAGE_TIMER, 8'h00};
		bus_write(addr, 8'h5a);
		for (int c = 0; c < 3 * aznable_pkg::MS_TICKS + 100; c++)
			@(posedge clk_24);
		bus_read(addr, lo);
		addr.paged.offset = 8'h01;
		bus_read(addr, hi);
		check_count("timer after three ms", int'({hi, lo}), 3);
		// clear again and read straight away
		addr.paged.offset = 8'h00;
		bus_write(addr, 8'h00);
		bus_read(addr, lo);
		addr.paged.offset = 8'h01;
		bus_read(addr, hi);
		check_count("timer right after clear", int'({hi, lo}), 0);
	endtask

	initial
	begin
		reset = 1'b1;
		dn_addr = '0;
		dn_data = '0;
		dn_index = '0;
		dn_wr = 1'b0;
		cpu_addr = '0;
		cpu_dout = '0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		joystick = '0;
		paddle = '0;
		ps2_key = '0;
		timestamp = '0;
		lfsr_state = 32'hce59d79d;
		repeat (5) @(posedge clk_24);
		reset <= 1'b0;
		@(posedge clk_24);
		test_pgrom_download();
		test_work_ram();
		test_input_pages();
		test_video_timing();
		test_ms_timer();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
aznable_pkg.sv
video_timer.sv
ms_timer.sv
bus_decoder.sv
system_memory.sv
system_top.sv
tb_system.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ns -f flist.f --top-module tb_system -o tb_system \
	&& ./obj_dir/tb_system | tee sim.log \
	|| echo "build or simulation did not complete"
grep -qx "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
